//--- list.f
source/rs_config_pkg.sv
source/rs_op_pkg.sv
source/rs_dispatch.sv
source/reservation_station.sv
source/rs_table.sv
source/rs_execute.sv
source/rs_issue_top.sv
testbench/rs_issue_assertions.sv
testbench/rs_issue_tb.sv

//--- source/reservation_station.sv
/*
   reservation station entry
   holds one instruction, waits on the CDB for missing operands and
   returns to empty when granted
*/
`timescale 1ns/10ps
`default_nettype none

module reservation_station
(
   input  wire                        clock,
   input  wire                        reset,
   input  wire                        fill,
   input  wire rs_op_pkg::op_t        fill_op,
   input  wire rs_config_pkg::reg_t   fill_dest,
   input  wire rs_config_pkg::tag_t   fill_a_tag,
   input  wire rs_config_pkg::tag_t   fill_b_tag,
   input  wire rs_config_pkg::value_t fill_a_value,
   input  wire rs_config_pkg::value_t fill_b_value,
   input  wire                        cdb_valid,
   input  wire rs_config_pkg::tag_t   cdb_tag,
   input  wire rs_config_pkg::value_t cdb_value,
   input  wire                        grant,
   output rs_op_pkg::station_state_t  state,
   output rs_op_pkg::op_t             op,
   output rs_config_pkg::reg_t        dest,
   output rs_config_pkg::value_t      a_value,
   output rs_config_pkg::value_t      b_value
);

   import rs_config_pkg::*;
   import rs_op_pkg::*;

   tag_t           a_tag;
   tag_t           b_tag;
   logic           a_hit;
   logic           b_hit;
   logic           a_waiting;
   logic           b_waiting;
   logic [1:0]     fill_wait;
   station_state_t next_state;

   assign a_hit     = cdb_valid && (cdb_tag == a_tag);
   assign b_hit     = cdb_valid && (cdb_tag == b_tag);
   assign a_waiting = (state == st_wait_a) || (state == st_wait_both);
   assign b_waiting = (state == st_wait_b) || (state == st_wait_both);
   assign fill_wait = {fill_a_tag != tag_null, fill_b_tag != tag_null};

   ////////////////////////////////////////////////////////////////////////////
   // state machine
   ////////////////////////////////////////////////////////////////////////////
   always_comb
   begin
      next_state = state;
      if (grant)
         next_state = st_empty;
      else if (fill)
      begin
         case (fill_wait)
            2'b11:   next_state = st_wait_both;
            2'b10:   next_state = st_wait_a;
            2'b01:   next_state = st_wait_b;
            default: next_state = st_ready;
         endcase
      end
      else
      begin
         case (state)
            st_wait_a:
               if (a_hit)
                  next_state = st_ready;
            st_wait_b:
               if (b_hit)
                  next_state = st_ready;
            st_wait_both:
            begin
               // both operands may name the same producer
               if (a_hit && b_hit)
                  next_state = st_ready;
               else if (a_hit)
                  next_state = st_wait_b;
               else if (b_hit)
                  next_state = st_wait_a;
            end
            default: next_state = state;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
         state <= st_empty;
      else
         state <= next_state;
   end

   // operand capture on fill or CDB wakeup
   always_ff @(posedge clock)
   begin
      if (fill)
      begin
         op      <= fill_op;
         dest    <= fill_dest;
         a_tag   <= fill_a_tag;
         b_tag   <= fill_b_tag;
         a_value <= fill_a_value;
         b_value <= fill_b_value;
      end
      else
      begin
         if (a_waiting && a_hit)
            a_value <= cdb_value;
         if (b_waiting && b_hit)
            b_value <= cdb_value;
      end
   end

endmodule

`default_nettype wire

//--- source/rs_config_pkg.sv
/*
   issue core configuration
   station count and the vector types for tags, values, registers,
   station masks and credits
*/
`default_nettype none

package rs_config_pkg;

   // number of reservation stations
   localparam int station_count = 8;

   // tag 0 means the operand is ready, 1 to 8 name station index plus one
   typedef logic [3:0] tag_t;
   localparam tag_t tag_null = 4'd0;

   // operand and result value
   typedef logic [63:0] value_t;

   // destination register number
   typedef logic [4:0] reg_t;

   // one bit per station, and a station number
   typedef logic [station_count-1:0] station_mask_t;
   typedef logic [2:0] station_index_t;

   // credit count, 0 to station_count
   typedef logic [3:0] credit_t;

endpackage

`default_nettype wire

//--- source/rs_dispatch.sv
/*
   dispatch stage
   registers an incoming instruction, picks the lowest free station and
   presents the fill with its tag one cycle later, with CDB bypass
*/
`timescale 1ns/10ps
`default_nettype none

module rs_dispatch
(
   input  wire                          clock,
   input  wire                          reset,
   input  wire                          dispatch_valid,
   input  wire rs_op_pkg::op_t          dispatch_op,
   input  wire rs_config_pkg::reg_t     dispatch_dest,
   input  wire rs_config_pkg::tag_t     src_a_tag,
   input  wire rs_config_pkg::tag_t     src_b_tag,
   input  wire rs_config_pkg::value_t   src_a_value,
   input  wire rs_config_pkg::value_t   src_b_value,
   input  wire rs_config_pkg::station_mask_t free_mask,
   input  wire                          cdb_valid,
   input  wire rs_config_pkg::tag_t     cdb_tag,
   input  wire rs_config_pkg::value_t   cdb_value,
   output rs_config_pkg::station_mask_t fill,
   output rs_op_pkg::op_t               fill_op,
   output rs_config_pkg::reg_t          fill_dest,
   output rs_config_pkg::tag_t          fill_a_tag,
   output rs_config_pkg::tag_t          fill_b_tag,
   output rs_config_pkg::value_t        fill_a_value,
   output rs_config_pkg::value_t        fill_b_value,
   output logic                         assigned_valid,
   output rs_config_pkg::tag_t          assigned_tag
);

   import rs_config_pkg::*;

   station_mask_t avail_mask;
   station_mask_t pick_mask;
   tag_t          pick_tag;
   logic          in_a_hit;
   logic          in_b_hit;
   logic          held_a_hit;
   logic          held_b_hit;
   tag_t          held_a_tag;
   tag_t          held_b_tag;
   value_t        held_a_value;
   value_t        held_b_value;

   // the station being filled this cycle still shows free, so mask it out
   always_comb
   begin
      avail_mask = free_mask & ~fill;
      pick_mask  = avail_mask & (~avail_mask + station_mask_t'(1));
      pick_tag   = tag_null;
      for (int i = 0; i < station_count; i++)
      begin
         if (pick_mask[i])
            pick_tag = tag_t'(i + 1);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // CDB bypass at input and while held
   ////////////////////////////////////////////////////////////////////////////
   assign in_a_hit   = cdb_valid && (src_a_tag != tag_null) && (src_a_tag == cdb_tag);
   assign in_b_hit   = cdb_valid && (src_b_tag != tag_null) && (src_b_tag == cdb_tag);
   assign held_a_hit = cdb_valid && (held_a_tag != tag_null) && (held_a_tag == cdb_tag);
   assign held_b_hit = cdb_valid && (held_b_tag != tag_null) && (held_b_tag == cdb_tag);

   assign fill_a_tag   = held_a_hit ? tag_null : held_a_tag;
   assign fill_b_tag   = held_b_hit ? tag_null : held_b_tag;
   assign fill_a_value = held_a_hit ? cdb_value : held_a_value;
   assign fill_b_value = held_b_hit ? cdb_value : held_b_value;

   assign assigned_valid = |fill;

   always_ff @(posedge clock)
   begin
      if (reset)
         fill <= '0;
      else
         fill <= dispatch_valid ? pick_mask : '0;
   end

   // held instruction fields
   always_ff @(posedge clock)
   begin
      if (dispatch_valid)
      begin
         fill_op      <= dispatch_op;
         fill_dest    <= dispatch_dest;
         assigned_tag <= pick_tag;
         held_a_tag   <= in_a_hit ? tag_null : src_a_tag;
         held_b_tag   <= in_b_hit ? tag_null : src_b_tag;
         held_a_value <= in_a_hit ? cdb_value : src_a_value;
         held_b_value <= in_b_hit ? cdb_value : src_b_value;
      end
   end

endmodule

`default_nettype wire

//--- source/rs_execute.sv
/*
   integer execute unit
   single-cycle ALU whose registered result is the CDB broadcast
*/
`timescale 1ns/10ps
`default_nettype none

module rs_execute
(
   input  wire                        clock,
   input  wire                        reset,
   input  wire                        issue_valid,
   input  wire rs_op_pkg::op_t        issue_op,
   input  wire rs_config_pkg::tag_t   issue_tag,
   input  wire rs_config_pkg::reg_t   issue_dest,
   input  wire rs_config_pkg::value_t issue_a,
   input  wire rs_config_pkg::value_t issue_b,
   output logic                       cdb_valid,
   output rs_config_pkg::tag_t        cdb_tag,
   output rs_config_pkg::reg_t        cdb_dest,
   output rs_config_pkg::value_t      cdb_value
);

   import rs_config_pkg::*;
   import rs_op_pkg::*;

   value_t result;

   always_comb
   begin
      case (issue_op)
         op_add:  result = issue_a + issue_b;
         op_sub:  result = issue_a - issue_b;
         op_and:  result = issue_a & issue_b;
         op_or:   result = issue_a | issue_b;
         op_xor:  result = issue_a ^ issue_b;
         // shift amount is the low 6 bits of b
         op_shl:  result = issue_a << issue_b[5:0];
         default: result = '0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
         cdb_valid <= 1'b0;
      else
         cdb_valid <= issue_valid;
   end

   always_ff @(posedge clock)
   begin
      if (issue_valid)
      begin
         cdb_tag   <= issue_tag;
         cdb_dest  <= issue_dest;
         cdb_value <= result;
      end
   end

endmodule

`default_nettype wire

//--- source/rs_issue_top.sv
/*
   issue side of the out-of-order core
   dispatch, station table with select, and execute, with the CDB fed
   back to dispatch and the stations
*/
`timescale 1ns/10ps
`default_nettype none

module rs_issue_top
(
   input  wire                        clock,
   input  wire                        reset,
   input  wire                        dispatch_valid,
   input  wire rs_op_pkg::op_t        dispatch_op,
   input  wire rs_config_pkg::reg_t   dispatch_dest,
   input  wire rs_config_pkg::tag_t   src_a_tag,
   input  wire rs_config_pkg::tag_t   src_b_tag,
   input  wire rs_config_pkg::value_t src_a_value,
   input  wire rs_config_pkg::value_t src_b_value,
   output logic                       assigned_valid,
   output rs_config_pkg::tag_t        assigned_tag,
   output logic                       credit_return,
   output logic                       cdb_valid,
   output rs_config_pkg::tag_t        cdb_tag,
   output rs_config_pkg::reg_t        cdb_dest,
   output rs_config_pkg::value_t      cdb_value
);

   import rs_config_pkg::*;
   import rs_op_pkg::*;

   // dispatch to table
   station_mask_t fill;
   station_mask_t free_mask;
   op_t           fill_op;
   reg_t          fill_dest;
   tag_t          fill_a_tag;
   tag_t          fill_b_tag;
   value_t        fill_a_value;
   value_t        fill_b_value;

   // table to execute
   logic          issue_valid;
   op_t           issue_op;
   tag_t          issue_tag;
   reg_t          issue_dest;
   value_t        issue_a;
   value_t        issue_b;

   rs_dispatch u_rs_dispatch
   (
      .clock          (clock),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch_op    (dispatch_op),
      .dispatch_dest  (dispatch_dest),
      .src_a_tag      (src_a_tag),
      .src_b_tag      (src_b_tag),
      .src_a_value    (src_a_value),
      .src_b_value    (src_b_value),
      .free_mask      (free_mask),
      .cdb_valid      (cdb_valid),
      .cdb_tag        (cdb_tag),
      .cdb_value      (cdb_value),
      .fill           (fill),
      .fill_op        (fill_op),
      .fill_dest      (fill_dest),
      .fill_a_tag     (fill_a_tag),
      .fill_b_tag     (fill_b_tag),
      .fill_a_value   (fill_a_value),
      .fill_b_value   (fill_b_value),
      .assigned_valid (assigned_valid),
      .assigned_tag   (assigned_tag)
   );

   rs_table u_rs_table
   (
      .clock         (clock),
      .reset         (reset),
      .fill          (fill),
      .fill_op       (fill_op),
      .fill_dest     (fill_dest),
      .fill_a_tag    (fill_a_tag),
      .fill_b_tag    (fill_b_tag),
      .fill_a_value  (fill_a_value),
      .fill_b_value  (fill_b_value),
      .cdb_valid     (cdb_valid),
      .cdb_tag       (cdb_tag),
      .cdb_value     (cdb_value),
      .free_mask     (free_mask),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .issue_tag     (issue_tag),
      .issue_dest    (issue_dest),
      .issue_a       (issue_a),
      .issue_b       (issue_b),
      .credit_return (credit_return)
   );

   rs_execute u_rs_execute
   (
      .clock       (clock),
      .reset       (reset),
      .issue_valid (issue_valid),
      .issue_op    (issue_op),
      .issue_tag   (issue_tag),
      .issue_dest  (issue_dest),
      .issue_a     (issue_a),
      .issue_b     (issue_b),
      .cdb_valid   (cdb_valid),
      .cdb_tag     (cdb_tag),
      .cdb_dest    (cdb_dest),
      .cdb_value   (cdb_value)
   );

endmodule

`default_nettype wire

//--- source/rs_op_pkg.sv
/*
   issue core encodings
   integer operations and reservation station states
*/
`default_nettype none

package rs_op_pkg;

   // op_shl shifts operand a left by the low 6 bits of operand b
   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_shl
   } op_t;

   typedef enum logic [2:0] {
      st_empty,
      st_wait_a,
      st_wait_b,
      st_wait_both,
      st_ready
   } station_state_t;

endpackage

`default_nettype wire

//--- source/rs_table.sv
/*
   reservation station table
   eight stations, free mask for dispatch, lowest-index ready select
   and one credit return per issued station
*/
`timescale 1ns/10ps
`default_nettype none

module rs_table
(
   input  wire                               clock,
   input  wire                               reset,
   input  wire rs_config_pkg::station_mask_t fill,
   input  wire rs_op_pkg::op_t               fill_op,
   input  wire rs_config_pkg::reg_t          fill_dest,
   input  wire rs_config_pkg::tag_t          fill_a_tag,
   input  wire rs_config_pkg::tag_t          fill_b_tag,
   input  wire rs_config_pkg::value_t        fill_a_value,
   input  wire rs_config_pkg::value_t        fill_b_value,
   input  wire                               cdb_valid,
   input  wire rs_config_pkg::tag_t          cdb_tag,
   input  wire rs_config_pkg::value_t        cdb_value,
   output rs_config_pkg::station_mask_t      free_mask,
   output logic                              issue_valid,
   output rs_op_pkg::op_t                    issue_op,
   output rs_config_pkg::tag_t               issue_tag,
   output rs_config_pkg::reg_t               issue_dest,
   output rs_config_pkg::value_t             issue_a,
   output rs_config_pkg::value_t             issue_b,
   output logic                              credit_return
);

   import rs_config_pkg::*;
   import rs_op_pkg::*;

   station_state_t station_state [station_count];
   op_t            station_op    [station_count];
   reg_t           station_dest  [station_count];
   value_t         station_a     [station_count];
   value_t         station_b     [station_count];
   station_mask_t  ready_mask;
   station_mask_t  grant_mask;
   station_index_t grant_index;

   for (genvar i = 0; i < station_count; i++)
   begin : g_station
      reservation_station u_station
      (
         .clock        (clock),
         .reset        (reset),
         .fill         (fill[i]),
         .fill_op      (fill_op),
         .fill_dest    (fill_dest),
         .fill_a_tag   (fill_a_tag),
         .fill_b_tag   (fill_b_tag),
         .fill_a_value (fill_a_value),
         .fill_b_value (fill_b_value),
         .cdb_valid    (cdb_valid),
         .cdb_tag      (cdb_tag),
         .cdb_value    (cdb_value),
         .grant        (grant_mask[i]),
         .state        (station_state[i]),
         .op           (station_op[i]),
         .dest         (station_dest[i]),
         .a_value      (station_a[i]),
         .b_value      (station_b[i])
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // masks and select
   ////////////////////////////////////////////////////////////////////////////
   always_comb
   begin
      for (int i = 0; i < station_count; i++)
      begin
         free_mask[i]  = (station_state[i] == st_empty);
         ready_mask[i] = (station_state[i] == st_ready);
      end
      // lowest set bit wins
      grant_mask  = ready_mask & (~ready_mask + station_mask_t'(1));
      grant_index = '0;
      for (int i = 0; i < station_count; i++)
      begin
         if (grant_mask[i])
            grant_index = station_index_t'(i);
      end
   end

   assign issue_valid = |ready_mask;
   assign issue_tag   = tag_t'(grant_index) + tag_t'(1);
   assign issue_op    = station_op[grant_index];
   assign issue_dest  = station_dest[grant_index];
   assign issue_a     = station_a[grant_index];
   assign issue_b     = station_b[grant_index];

   // granted station empties at this edge, credit goes back next cycle
   always_ff @(posedge clock)
   begin
      if (reset)
         credit_return <= 1'b0;
      else
         credit_return <= issue_valid;
   end

endmodule

`default_nettype wire

//--- testbench/rs_issue_assertions.sv
/*
   station table checks
   credit balance, fills into empty stations only, issue of the lowest ready station
*/
`timescale 1ns/10ps
`default_nettype none

module rs_issue_assertions
(
   input wire                               clock,
   input wire                               reset,
   input wire rs_config_pkg::station_mask_t fill,
   input wire rs_config_pkg::station_mask_t free_mask,
   input wire rs_config_pkg::station_mask_t ready_mask,
   input wire                               issue_valid,
   input wire rs_config_pkg::tag_t          issue_tag,
   input wire                               credit_return
);

   import rs_config_pkg::*;

   // stations filled and not yet returned as credits
   int outstanding;

   // number of failed assertions
   int error_count = 0;

   // issued station as a mask, and every station below it
   station_mask_t issue_bit;
   station_mask_t below_issue;

   assign issue_bit   = station_mask_t'(1) << (issue_tag - tag_t'(1));
   assign below_issue = issue_bit - station_mask_t'(1);

   always_ff @(posedge clock)
   begin
      if (reset)
         outstanding <= 0;
      else
         outstanding <= outstanding + $countones(fill) - int'(credit_return);
   end

   credit_after_fill: assert property (@(posedge clock) disable iff (reset)
      credit_return |-> (outstanding > 0))
   else
   begin
      error_count++;
      $error("credit returned with no filled station");
   end

   credit_bound: assert property (@(posedge clock) disable iff (reset)
      outstanding <= station_count)
   else
   begin
      error_count++;
      $error("more stations outstanding than exist");
   end

   fill_into_empty: assert property (@(posedge clock) disable iff (reset)
      (|fill) |-> ((fill & ~free_mask) == '0))
   else
   begin
      error_count++;
      $error("fill aimed at an occupied station");
   end

   grant_of_ready: assert property (@(posedge clock) disable iff (reset)
      issue_valid |-> (((issue_bit & ready_mask) != '0)
                       && ((below_issue & ready_mask) == '0)))
   else
   begin
      error_count++;
      $error("issue of a station that is not the lowest ready one");
   end

endmodule

bind rs_table rs_issue_assertions u_rs_issue_assertions
(
   .clock         (clock),
   .reset         (reset),
   .fill          (fill),
   .free_mask     (free_mask),
   .ready_mask    (ready_mask),
   .issue_valid   (issue_valid),
   .issue_tag     (issue_tag),
   .credit_return (credit_return)
);

`default_nettype wire

//--- testbench/rs_issue_tb.sv
/*
   issue core testbench
   applies a table of dependent and independent instructions under credit
   flow control and checks every CDB broadcast against a reference model
*/
`timescale 1ns/10ps
`default_nettype none

module rs_issue_tb;

   import rs_config_pkg::*;
   import rs_op_pkg::*;

   localparam int clock_period = 100;
   localparam int reset_cycles = 10;
   localparam int max_rows     = 40;
   // sample edge, station write, then the broadcast edge
   localparam int lone_latency = 3;

   logic   clock;
   logic   reset;
   logic   dispatch_valid;
   op_t    dispatch_op;
   reg_t   dispatch_dest;
   tag_t   src_a_tag;
   tag_t   src_b_tag;
   value_t src_a_value;
   value_t src_b_value;
   logic   assigned_valid;
   tag_t   assigned_tag;
   logic   credit_return;
   logic   cdb_valid;
   tag_t   cdb_tag;
   reg_t   cdb_dest;
   value_t cdb_value;

   // stimulus table, a dependency of -1 means a literal operand
   op_t    t_op    [max_rows];
   int     t_a_dep [max_rows];
   int     t_b_dep [max_rows];
   int     t_gap   [max_rows];
   bit     t_lone  [max_rows];
   value_t t_a_lit [max_rows];
   value_t t_b_lit [max_rows];
   int     row_count;

   // per-row progress
   value_t expected   [max_rows];
   tag_t   row_tag    [max_rows];
   bit     tag_known  [max_rows];
   bit     done       [max_rows];
   int     done_cycle [max_rows];
   int     sent_cycle [max_rows];
   int     assign_q   [$];

   logic [31:0] rng_state;
   int          cycle;
   int          credits;
   int          dispatched;
   int          completed;
   int          returns;
   int          stalls;

   rs_issue_top u_rs_issue_top
   (
      .clock          (clock),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch_op    (dispatch_op),
      .dispatch_dest  (dispatch_dest),
      .src_a_tag      (src_a_tag),
      .src_b_tag      (src_b_tag),
      .src_a_value    (src_a_value),
      .src_b_value    (src_b_value),
      .assigned_valid (assigned_valid),
      .assigned_tag   (assigned_tag),
      .credit_return  (credit_return),
      .cdb_valid      (cdb_valid),
      .cdb_tag        (cdb_tag),
      .cdb_dest       (cdb_dest),
      .cdb_value      (cdb_value)
   );

   initial
   begin
      clock = 1'b0;
      forever
         #(clock_period / 2) clock = ~clock;
   end

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic value_t random_value();
      value_t v;
      rng_state = xorshift32(rng_state);
      v[63:32]  = rng_state;
      rng_state = xorshift32(rng_state);
      v[31:0]   = rng_state;
      return v;
   endfunction

   // reference ALU from the op rules
   function automatic value_t model_result(op_t op, value_t a, value_t b);
      case (op)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         op_shl:  return a << b[5:0];
         default: return '0;
      endcase
   endfunction

   task automatic stop_with_failure();
      $display("=== FAIL ===");
      $fatal(1, "test stopped");
   endtask

   task automatic report_mismatch(string msg);
      $display("mismatch at %0t: %s", $time, msg);
      stop_with_failure();
   endtask

   task automatic compare_value(value_t got, value_t exp, string what);
      if (got !== exp)
         report_mismatch($sformatf("%s value %h, expected %h", what, got, exp));
   endtask

   task automatic compare_tag(tag_t got, tag_t exp, string what);
      if (got !== exp)
         report_mismatch($sformatf("%s tag %0d, expected %0d", what, got, exp));
   endtask

   task automatic compare_dest(reg_t got, reg_t exp, string what);
      if (got !== exp)
         report_mismatch($sformatf("%s dest %0d, expected %0d", what, got, exp));
   endtask

   task automatic add_row(op_t op, int a_dep, int b_dep, int gap, bit lone);
      t_op[row_count]    = op;
      t_a_dep[row_count] = a_dep;
      t_b_dep[row_count] = b_dep;
      t_gap[row_count]   = gap;
      t_lone[row_count]  = lone;
      t_a_lit[row_count] = random_value();
      t_b_lit[row_count] = random_value();
      row_count++;
   endtask

   task automatic build_table();
      op_t op;
      // every op alone
      add_row(op_add, -1, -1, 2, 1);
      add_row(op_sub, -1, -1, 2, 1);
      add_row(op_and, -1, -1, 2, 1);
      add_row(op_or,  -1, -1, 2, 1);
      add_row(op_xor, -1, -1, 2, 1);
      add_row(op_shl, -1, -1, 2, 1);
      // short dependent chain
      add_row(op_add, -1, -1, 0, 0);
      add_row(op_sub,  6, -1, 0, 0);
      add_row(op_xor,  7,  6, 0, 0);
      add_row(op_shl,  8, -1, 0, 0);
      add_row(op_and,  9,  9, 0, 0);
      // input bypass on row 12, held bypass on row 13
      add_row(op_or,  -1, -1, 1, 1);
      add_row(op_add, 11, -1, 2, 0);
      add_row(op_sub, 12, 11, 1, 0);
      // long back-to-back chain drains the credits
      add_row(op_xor, -1, -1, 0, 1);
      op = op_add;
      for (int i = 15; i < 32; i++)
      begin
         add_row(op, i - 1, -1, 0, 0);
         op = (op == op_shl) ? op_add : op_t'(op + 1);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // output sampling, once per falling edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic sample_outputs();
      int r;
      if (u_rs_issue_top.u_rs_table.u_rs_issue_assertions.error_count != 0)
      begin
         $display("assertion failed inside the station table");
         stop_with_failure();
      end
      if (credit_return)
      begin
         credits++;
         returns++;
         if (credits > station_count)
         begin
            $display("credit returned with all credits already held");
            stop_with_failure();
         end
      end
      if (assigned_valid)
      begin
         if (assign_q.size() == 0)
         begin
            $display("assigned_valid without a dispatch");
            stop_with_failure();
         end
         r = assign_q.pop_front();
         row_tag[r]   = assigned_tag;
         tag_known[r] = 1'b1;
         // an empty table hands out the lowest station
         if (t_lone[r])
            compare_tag(assigned_tag, tag_t'(1), $sformatf("row %0d assigned", r));
      end
      if (cdb_valid)
      begin
         r = -1;
         for (int i = 0; i < row_count; i++)
         begin
            if (tag_known[i] && !done[i] && row_tag[i] == cdb_tag)
               r = i;
         end
         if (r < 0)
            report_mismatch($sformatf("broadcast of tag %0d with no row waiting", cdb_tag));
         compare_dest(cdb_dest, reg_t'(r), $sformatf("row %0d", r));
         compare_value(cdb_value, expected[r], $sformatf("row %0d", r));
         if (t_lone[r] && cycle != sent_cycle[r] + lone_latency)
            report_mismatch($sformatf("row %0d broadcast after %0d cycles",
                                      r, cycle - sent_cycle[r]));
         done[r]       = 1'b1;
         done_cycle[r] = cycle;
         completed++;
      end
   endtask

   task automatic step();
      @(negedge clock);
      cycle++;
      sample_outputs();
   endtask

   // source operand as the rename stage would send it
   task automatic resolve_source(int dep, value_t lit, output tag_t tag, output value_t value);
      if (dep < 0)
      begin
         tag   = tag_null;
         value = lit;
      end
      else if (done[dep] && done_cycle[dep] < cycle)
      begin
         tag   = tag_null;
         value = expected[dep];
      end
      else
      begin
         if (!tag_known[dep])
         begin
            $display("producer row %0d has no tag yet", dep);
            stop_with_failure();
         end
         tag = row_tag[dep];
         // ignored by the design while the tag is non-null
         value = random_value();
      end
   endtask

   task automatic send_row(int r);
      value_t a;
      value_t b;
      a = (t_a_dep[r] < 0) ? t_a_lit[r] : expected[t_a_dep[r]];
      b = (t_b_dep[r] < 0) ? t_b_lit[r] : expected[t_b_dep[r]];
      expected[r] = model_result(t_op[r], a, b);
      resolve_source(t_a_dep[r], t_a_lit[r], src_a_tag, src_a_value);
      resolve_source(t_b_dep[r], t_b_lit[r], src_b_tag, src_b_value);
      dispatch_valid = 1'b1;
      dispatch_op    = t_op[r];
      dispatch_dest  = reg_t'(r);
      sent_cycle[r]  = cycle;
      credits--;
      dispatched++;
      assign_q.push_back(r);
      step();
      dispatch_valid = 1'b0;
      // the tag comes back in the cycle after the dispatch
      if (!tag_known[r])
      begin
         $display("no tag assigned in the cycle after row %0d was sent", r);
         stop_with_failure();
      end
   endtask

   initial
   begin
      reset          = 1'b1;
      dispatch_valid = 1'b0;
      dispatch_op    = op_add;
      dispatch_dest  = '0;
      src_a_tag      = tag_null;
      src_b_tag      = tag_null;
      src_a_value    = '0;
      src_b_value    = '0;
      rng_state      = 32'hcdfc;
      row_count      = 0;
      cycle          = 0;
      credits        = station_count;
      dispatched     = 0;
      completed      = 0;
      returns        = 0;
      stalls         = 0;
      for (int i = 0; i < max_rows; i++)
      begin
         tag_known[i] = 1'b0;
         done[i]      = 1'b0;
      end
      build_table();
      repeat (reset_cycles)
         @(negedge clock);
      reset = 1'b0;

      // idle after reset, every output must stay quiet
      repeat (4)
         step();

      for (int r = 0; r < row_count; r++)
      begin
         repeat (t_gap[r])
            step();
         if (t_lone[r])
         begin
            while (dispatched != completed)
               step();
         end
         while (credits == 0)
         begin
            stalls++;
            step();
         end
         send_row(r);
      end

      while (dispatched != completed)
         step();
      repeat (4)
         step();

      if (returns == dispatched && credits == station_count && stalls > 0)
      begin
         $display("=== PASS ===");
         $finish;
      end
      else
      begin
         $display("credit totals wrong: %0d returned, %0d dispatched, %0d stalls",
                  returns, dispatched, stalls);
         $display("=== FAIL ===");
         $fatal(1, "credit check failed");
      end
   end

   // watchdog
   initial
   begin
      #1;
      #(clock_period * (reset_cycles + row_count * 20));
      $display("timeout before all results were broadcast");
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire
